// File: vlog.f
logic/bridge_pkg.sv
logic/axi_req_mapper.sv
logic/rd_id_fifo.sv
logic/axi_rsp_builder.sv
logic/axi2avmm_bridge.sv
testbench/axi2avmm_bridge_chk.sv
testbench/tb_axi2avmm_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the bridge testbench with verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_axi2avmm_bridge \
  -f vlog.f -o tb_sim > build.log 2>&1 \
  || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
grep -qx "TEST PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// File: testbench/tb_axi2avmm_bridge.sv
// ====================
// axi4 to avmm bridge testbench
// directed write, read order, priority, stall and throttle tests
// ====================
`timescale 1ns/1ps

module tb_axi2avmm_bridge;

  localparam int ADDR_W     = bridge_pkg::DEF_ADDR_W;
  localparam int DATA_W     = bridge_pkg::DEF_DATA_W;
  localparam int ID_W       = bridge_pkg::DEF_ID_W;
  localparam int LINE_W     = ADDR_W - bridge_pkg::LINE_OFS_W;
  localparam int CLK_PERIOD = 100;
  // cycles per test in run order: reset, write, read, priority, stall, throttle
  localparam int TEST_CYCLES = 3 + 12 + 20 + 10 + 6 + 30;

  logic                  ip_clk = 1'b0;
  logic                  ip_rst_n;
  logic                  i_awvalid, i_wuser, i_arvalid;
  logic [ID_W-1:0]       i_awid, i_arid;
  logic [ADDR_W-1:0]     i_awaddr, i_araddr;
  logic [DATA_W-1:0]     i_wdata, i_avmm_readdata;
  logic [DATA_W/8-1:0]   i_wstrb;
  logic                  i_avmm_ready, i_avmm_readdatavalid, i_avmm_read_poison;
  logic                  o_awready, o_wready, o_arready;
  logic                  o_bvalid, o_rvalid, o_rlast, o_ruser_poison;
  logic [ID_W-1:0]       o_bid, o_rid;
  bridge_pkg::axi_resp_e o_bresp, o_rresp;
  logic [DATA_W-1:0]     o_rdata, o_avmm_writedata;
  logic                  o_avmm_write, o_avmm_read, o_avmm_write_poison;
  logic [LINE_W-1:0]     o_avmm_address;
  logic [DATA_W/8-1:0]   o_avmm_byteenable;

  integer          seed;
  int              error_count;
  int              test_count;
  logic [ID_W-1:0] exp_rd_ids[$]; // read ids in request order

  axi2avmm_bridge #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W), .ID_W(ID_W),
    .FIFO_DEPTH(bridge_pkg::DEF_FIFO_DEPTH), .AF_MARGIN(bridge_pkg::DEF_AF_MARGIN)
  ) uut (.*);

  always #(CLK_PERIOD/2) ip_clk = ~ip_clk;

  // ====================
  // helpers
  // ====================
  task automatic report_mismatch(input string name, input string exp, input string act);
    error_count++;
    $display("CHECK FAILED at %0t ns: %s expected %s got %s", $time, name, exp, act);
  endtask

  task automatic report_problem(input string msg);
    error_count++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic next_cycle();
    @(posedge ip_clk);
    #5; // inputs change just after the edge
  endtask

  task automatic idle_inputs();
    i_awvalid            = 1'b0;
    i_arvalid            = 1'b0;
    i_avmm_readdatavalid = 1'b0;
  endtask

  task automatic rand_line(output logic [DATA_W-1:0] v);
    for (int i = 0; i < DATA_W/32; i++)
      v[i*32 +: 32] = $random(seed);
  endtask

  task automatic rand_addr(output logic [ADDR_W-1:0] a);
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    a = r[ADDR_W-1:0];
  endtask

  // cache line address, byte offset dropped
  function automatic logic [LINE_W-1:0] line_addr(input logic [ADDR_W-1:0] a);
    line_addr = LINE_W'(a >> bridge_pkg::LINE_OFS_W);
  endfunction

  // hold arvalid until arready, bounded wait
  task automatic issue_read(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr);
    int waited;
    waited = 0;
    next_cycle();
    i_arvalid = 1'b1;
    i_arid    = id;
    i_araddr  = addr;
    @(negedge ip_clk);
    while (!o_arready && waited < 4)
    begin
      @(negedge ip_clk);
      waited++;
    end
    if (!o_arready)
      report_problem($sformatf("read id %h was not accepted within 4 cycles", id));
    else
    begin
      exp_rd_ids.push_back(id);
      if (o_avmm_read !== 1'b1)
        report_mismatch("o_avmm_read", "1", $sformatf("%b", o_avmm_read));
      if (o_avmm_address !== line_addr(addr))
        report_mismatch("o_avmm_address", $sformatf("%h", line_addr(addr)),
                        $sformatf("%h", o_avmm_address));
    end
  endtask

  // one read data strobe, response must carry the oldest id
  task automatic return_read();
    logic [DATA_W-1:0] data;
    logic [31:0]       r;
    logic [ID_W-1:0]   exp_id;
    rand_line(data);
    r      = $random(seed);
    exp_id = exp_rd_ids.pop_front();
    next_cycle();
    i_avmm_readdatavalid = 1'b1;
    i_avmm_readdata      = data;
    i_avmm_read_poison   = r[0];
    @(negedge ip_clk);
    if (o_rvalid !== 1'b1)
      report_mismatch("o_rvalid", "1", $sformatf("%b", o_rvalid));
    if (o_rid !== exp_id)
      report_mismatch("o_rid", $sformatf("%h", exp_id), $sformatf("%h", o_rid));
    if (o_rdata !== data)
      report_mismatch("o_rdata", $sformatf("%h", data), $sformatf("%h", o_rdata));
    if (o_ruser_poison !== r[0])
      report_mismatch("o_ruser_poison", $sformatf("%b", r[0]), $sformatf("%b", o_ruser_poison));
    if (o_rlast !== 1'b1)
      report_mismatch("o_rlast", "1", $sformatf("%b", o_rlast));
    if (o_rresp !== bridge_pkg::RESP_OKAY)
      report_mismatch("o_rresp", "0", $sformatf("%0d", o_rresp));
  endtask

  // ====================
  // tests
  // ====================
  task automatic test_write_mapping();
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] strb;
    logic [31:0]         r;
    logic [ID_W-1:0]     id;
    test_count++;
    for (int n = 0; n < 3; n++)
    begin
      rand_addr(addr);
      rand_line(data);
      strb = {$random(seed), $random(seed)};
      r    = $random(seed);
      id   = ID_W'(8'h40 + n);
      next_cycle();
      i_awvalid = 1'b1;
      i_awid    = id;
      i_awaddr  = addr;
      i_wdata   = data;
      i_wstrb   = strb;
      i_wuser   = r[0];
      @(negedge ip_clk);
      if (o_avmm_write !== 1'b1 || o_avmm_read !== 1'b0)
        report_mismatch("o_avmm_write/o_avmm_read", "10",
                        $sformatf("%b%b", o_avmm_write, o_avmm_read));
      if (o_avmm_address !== line_addr(addr))
        report_mismatch("o_avmm_address", $sformatf("%h", line_addr(addr)),
                        $sformatf("%h", o_avmm_address));
      if (o_avmm_writedata !== data)
        report_mismatch("o_avmm_writedata", $sformatf("%h", data),
                        $sformatf("%h", o_avmm_writedata));
      if (o_avmm_byteenable !== strb)
        report_mismatch("o_avmm_byteenable", $sformatf("%h", strb),
                        $sformatf("%h", o_avmm_byteenable));
      if (o_avmm_write_poison !== r[0])
        report_mismatch("o_avmm_write_poison", $sformatf("%b", r[0]),
                        $sformatf("%b", o_avmm_write_poison));
      if (o_bvalid !== 1'b0) // previous pulse must be over
        report_mismatch("o_bvalid", "0", $sformatf("%b", o_bvalid));
      next_cycle();
      idle_inputs();
      @(negedge ip_clk);
      if (o_bvalid !== 1'b1)
        report_mismatch("o_bvalid", "1", $sformatf("%b", o_bvalid));
      if (o_bid !== id)
        report_mismatch("o_bid", $sformatf("%h", id), $sformatf("%h", o_bid));
      if (o_bresp !== bridge_pkg::RESP_OKAY)
        report_mismatch("o_bresp", "0", $sformatf("%0d", o_bresp));
    end
    next_cycle();
    @(negedge ip_clk);
    if (o_bvalid !== 1'b0)
      report_mismatch("o_bvalid", "0", $sformatf("%b", o_bvalid));
  endtask

  task automatic test_read_ordering();
    logic [ID_W-1:0]   ids [4];
    logic [ADDR_W-1:0] addr;
    test_count++;
    ids = '{8'h5a, 8'h13, 8'hc7, 8'h81};
    for (int n = 0; n < 4; n++)
    begin
      rand_addr(addr);
      issue_read(ids[n], addr);
    end
    next_cycle();
    idle_inputs();
    while (exp_rd_ids.size() > 0)
      return_read();
    next_cycle();
    idle_inputs();
    @(negedge ip_clk);
    if (o_rvalid !== 1'b0)
      report_mismatch("o_rvalid", "0", $sformatf("%b", o_rvalid));
  endtask

  task automatic test_write_priority();
    logic [ADDR_W-1:0] waddr;
    logic [ADDR_W-1:0] raddr;
    test_count++;
    rand_addr(waddr);
    rand_addr(raddr);
    next_cycle();
    i_awvalid = 1'b1;     // write and read valid together
    i_awid    = 8'h21;
    i_awaddr  = waddr;
    i_wstrb   = '1;
    i_arvalid = 1'b1;
    i_arid    = 8'h22;
    i_araddr  = raddr;
    @(negedge ip_clk);
    if (o_avmm_write !== 1'b1 || o_avmm_read !== 1'b0)
      report_mismatch("o_avmm_write/o_avmm_read", "10",
                      $sformatf("%b%b", o_avmm_write, o_avmm_read));
    if (o_avmm_address !== line_addr(waddr))
      report_mismatch("o_avmm_address", $sformatf("%h", line_addr(waddr)),
                      $sformatf("%h", o_avmm_address));
    next_cycle();
    i_awvalid = 1'b0;     // read stays pending
    @(negedge ip_clk);
    if (o_avmm_read !== 1'b1 || o_avmm_write !== 1'b0)
      report_mismatch("o_avmm_write/o_avmm_read", "01",
                      $sformatf("%b%b", o_avmm_write, o_avmm_read));
    if (o_avmm_address !== line_addr(raddr))
      report_mismatch("o_avmm_address", $sformatf("%h", line_addr(raddr)),
                      $sformatf("%h", o_avmm_address));
    if (o_bvalid !== 1'b1 || o_bid !== 8'h21)
      report_mismatch("o_bvalid/o_bid", "1/21", $sformatf("%b/%h", o_bvalid, o_bid));
    exp_rd_ids.push_back(8'h22);
    next_cycle();
    idle_inputs();
    return_read();
    next_cycle();
    idle_inputs();
  endtask

  task automatic test_not_ready();
    test_count++;
    next_cycle();
    i_avmm_ready = 1'b0;
    i_awvalid    = 1'b1;
    i_arvalid    = 1'b1;
    repeat (2)
    begin
      @(negedge ip_clk);
      if ({o_awready, o_wready, o_arready} !== 3'b000)
        report_mismatch("o_awready/o_wready/o_arready", "000",
                        $sformatf("%b%b%b", o_awready, o_wready, o_arready));
      if (o_avmm_write !== 1'b0 || o_avmm_read !== 1'b0)
        report_mismatch("o_avmm_write/o_avmm_read", "00",
                        $sformatf("%b%b", o_avmm_write, o_avmm_read));
      next_cycle();
    end
    idle_inputs();
    i_avmm_ready = 1'b1;
    @(negedge ip_clk);
    if (o_bvalid !== 1'b0) // nothing was accepted
      report_mismatch("o_bvalid", "0", $sformatf("%b", o_bvalid));
  endtask

  task automatic test_read_throttle();
    logic [ADDR_W-1:0] addr;
    int                waited;
    test_count++;
    for (int n = 0; n < 8; n++)
    begin
      rand_addr(addr);
      issue_read(ID_W'(8'h80 + n), addr);
    end
    next_cycle();
    i_arid = 8'hf0; // ninth read held at the input
    @(negedge ip_clk);
    if (o_arready !== 1'b0 || o_avmm_read !== 1'b0)
      report_mismatch("o_arready/o_avmm_read", "00",
                      $sformatf("%b%b", o_arready, o_avmm_read));
    if (o_awready !== 1'b1 || o_wready !== 1'b1)
      report_mismatch("o_awready/o_wready", "11", $sformatf("%b%b", o_awready, o_wready));
    return_read();
    next_cycle();
    i_avmm_readdatavalid = 1'b0;
    @(negedge ip_clk);
    waited = 1;
    while (!o_arready && waited < 2)
    begin
      @(negedge ip_clk);
      waited++;
    end
    if (o_arready === 1'b1)
      exp_rd_ids.push_back(8'hf0);
    else
      report_problem("arready did not return within two cycles of read data");
    next_cycle();
    idle_inputs();
    while (exp_rd_ids.size() > 0)
      return_read();
    next_cycle();
    idle_inputs();
  endtask

  // ====================
  // main sequence
  // ====================
  initial
  begin
    seed                 = 32'hc565_ac81;
    error_count          = 0;
    test_count           = 0;
    ip_rst_n             = 1'b0;
    i_avmm_ready         = 1'b0;
    i_awid               = '0;
    i_awaddr             = '0;
    i_wdata              = '0;
    i_wstrb              = '0;
    i_wuser              = 1'b0;
    i_arid               = '0;
    i_araddr             = '0;
    i_avmm_readdata      = '0;
    i_avmm_read_poison   = 1'b0;
    idle_inputs();
    repeat (2) @(posedge ip_clk);
    #5;
    ip_rst_n     = 1'b1;
    i_avmm_ready = 1'b1;
    @(negedge ip_clk);
    if ({o_avmm_write, o_avmm_read, o_bvalid, o_rvalid} !== 4'b0000)
      report_mismatch("write/read/bvalid/rvalid after reset", "0000",
                      $sformatf("%b%b%b%b", o_avmm_write, o_avmm_read, o_bvalid, o_rvalid));

    test_write_mapping();
    test_read_ordering();
    test_write_priority();
    test_not_ready();
    test_read_throttle();

    $display("tests run: %0d, errors: %0d", test_count, error_count);
    if (error_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // watchdog, test length plus half again
  initial
  begin
    #(TEST_CYCLES * CLK_PERIOD * 3 / 2);
    $display("watchdog expired after %0d cycles, tests did not finish", TEST_CYCLES * 3 / 2);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: testbench/axi2avmm_bridge_chk.sv
// ====================
// bridge protocol checker
// bound onto the top level, watches response pulses and controller strobes
// ====================
`timescale 1ns/1ps

module axi2avmm_bridge_chk (
  input logic ip_clk,
  input logic ip_rst_n,
  input logic i_wr_acc,         // write taken this cycle
  input logic i_avmm_write,
  input logic i_avmm_read,
  input logic i_bvalid,
  input logic i_readdatavalid
);

  bridge_pkg::req_kind_e kind;  // what went to the controller this cycle
  logic [7:0]            rd_outstanding; // reads sent minus data returned

  always_comb
  begin
    if (i_avmm_write)
      kind = bridge_pkg::REQ_WRITE;
    else if (i_avmm_read)
      kind = bridge_pkg::REQ_READ;
    else
      kind = bridge_pkg::REQ_NONE;
  end

  // own count, kept apart from the id buffer
  always_ff @(posedge ip_clk)
  begin
    if (!ip_rst_n)
      rd_outstanding <= '0;
    else if ((kind == bridge_pkg::REQ_READ) && !i_readdatavalid)
      rd_outstanding <= rd_outstanding + 1'b1;
    else if ((kind != bridge_pkg::REQ_READ) && i_readdatavalid)
      rd_outstanding <= rd_outstanding - 1'b1;
  end

  // ====================
  // rules
  // ====================

  // bvalid drops after one cycle unless a write lands right behind it
  a_bvalid_pulse: assert property (@(posedge ip_clk) disable iff (!ip_rst_n)
    (i_bvalid && !i_wr_acc) |=> !i_bvalid)
    else $error("bvalid stayed high with no new write accepted");

  a_rdata_outstanding: assert property (@(posedge ip_clk) disable iff (!ip_rst_n)
    i_readdatavalid |-> (rd_outstanding != '0))
    else $error("read data returned with no read outstanding");

  a_one_strobe: assert property (@(posedge ip_clk) disable iff (!ip_rst_n)
    !(i_avmm_write && i_avmm_read))
    else $error("controller write and read strobes high together");

endmodule

bind axi2avmm_bridge axi2avmm_bridge_chk u_bridge_chk (
  .ip_clk(ip_clk), .ip_rst_n(ip_rst_n), .i_wr_acc(wr_acc),
  .i_avmm_write(o_avmm_write), .i_avmm_read(o_avmm_read),
  .i_bvalid(o_bvalid), .i_readdatavalid(i_avmm_readdatavalid)
);

// File: logic/axi2avmm_bridge.sv
// ====================
// axi4 to avmm bridge top
// request mapper, read id buffer and response builder
// ====================
`timescale 1ns/1ps

module axi2avmm_bridge #(
  parameter int ADDR_W     = bridge_pkg::DEF_ADDR_W,
  parameter int DATA_W     = bridge_pkg::DEF_DATA_W,
  parameter int ID_W       = bridge_pkg::DEF_ID_W,
  parameter int FIFO_DEPTH = bridge_pkg::DEF_FIFO_DEPTH,
  parameter int AF_MARGIN  = bridge_pkg::DEF_AF_MARGIN
) (
  input  logic                                   ip_clk,
  input  logic                                   ip_rst_n,
  // axi request side
  input  logic                                   i_awvalid,
  input  logic [ID_W-1:0]                        i_awid,
  input  logic [ADDR_W-1:0]                      i_awaddr,
  input  logic [DATA_W-1:0]                      i_wdata,
  input  logic [DATA_W/8-1:0]                    i_wstrb,
  input  logic                                   i_wuser,
  input  logic                                   i_arvalid,
  input  logic [ID_W-1:0]                        i_arid,
  input  logic [ADDR_W-1:0]                      i_araddr,
  output logic                                   o_awready,
  output logic                                   o_wready,
  output logic                                   o_arready,
  // axi response side, never back-pressured
  output logic                                   o_bvalid,
  output logic [ID_W-1:0]                        o_bid,
  output bridge_pkg::axi_resp_e                  o_bresp,
  output logic                                   o_rvalid,
  output logic [ID_W-1:0]                        o_rid,
  output logic [DATA_W-1:0]                      o_rdata,
  output bridge_pkg::axi_resp_e                  o_rresp,
  output logic                                   o_rlast,
  output logic                                   o_ruser_poison,
  // avmm controller side
  output logic                                   o_avmm_write,
  output logic                                   o_avmm_read,
  output logic [ADDR_W-bridge_pkg::LINE_OFS_W-1:0] o_avmm_address,
  output logic [DATA_W-1:0]                      o_avmm_writedata,
  output logic [DATA_W/8-1:0]                    o_avmm_byteenable,
  output logic                                   o_avmm_write_poison,
  input  logic                                   i_avmm_ready,
  input  logic                                   i_avmm_readdatavalid,
  input  logic [DATA_W-1:0]                      i_avmm_readdata,
  input  logic                                   i_avmm_read_poison
);

  logic            wr_acc;         // write taken this cycle
  logic [ID_W-1:0] wr_acc_id;
  logic            rd_push;        // read taken this cycle
  logic [ID_W-1:0] rd_push_id;
  logic            rd_almost_full; // throttles arready
  logic            rd_pop;         // read data came back
  logic [ID_W-1:0] rd_head_id;

  // ====================
  // request path
  // ====================
  axi_req_mapper #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .ID_W(ID_W)) u_req_mapper (
    .i_avmm_ready(i_avmm_ready), .i_rd_almost_full(rd_almost_full),
    .i_awvalid(i_awvalid), .i_awid(i_awid), .i_awaddr(i_awaddr),
    .i_wdata(i_wdata), .i_wstrb(i_wstrb), .i_wuser(i_wuser),
    .i_arvalid(i_arvalid), .i_arid(i_arid), .i_araddr(i_araddr),
    .o_awready(o_awready), .o_wready(o_wready), .o_arready(o_arready),
    .o_avmm_write(o_avmm_write), .o_avmm_read(o_avmm_read), .o_avmm_address(o_avmm_address),
    .o_avmm_writedata(o_avmm_writedata), .o_avmm_byteenable(o_avmm_byteenable),
    .o_avmm_write_poison(o_avmm_write_poison),
    .o_wr_acc(wr_acc), .o_wr_acc_id(wr_acc_id),
    .o_rd_push(rd_push), .o_rd_push_id(rd_push_id)
  );

  // read ids wait here until data returns
  rd_id_fifo #(.ID_W(ID_W), .FIFO_DEPTH(FIFO_DEPTH), .AF_MARGIN(AF_MARGIN)) u_rd_id_fifo (
    .ip_clk(ip_clk), .ip_rst_n(ip_rst_n),
    .i_push(rd_push), .i_push_id(rd_push_id), .i_pop(rd_pop),
    .o_head_id(rd_head_id), .o_almost_full(rd_almost_full)
  );

  // ====================
  // response path
  // ====================
  axi_rsp_builder #(.DATA_W(DATA_W), .ID_W(ID_W)) u_rsp_builder (
    .ip_clk(ip_clk), .ip_rst_n(ip_rst_n),
    .i_wr_acc(wr_acc), .i_wr_acc_id(wr_acc_id),
    .i_avmm_readdatavalid(i_avmm_readdatavalid), .i_avmm_readdata(i_avmm_readdata),
    .i_avmm_read_poison(i_avmm_read_poison), .i_head_id(rd_head_id),
    .o_bvalid(o_bvalid), .o_bid(o_bid), .o_bresp(o_bresp),
    .o_rvalid(o_rvalid), .o_rid(o_rid), .o_rdata(o_rdata), .o_rresp(o_rresp),
    .o_rlast(o_rlast), .o_ruser_poison(o_ruser_poison), .o_rd_pop(rd_pop)
  );

endmodule

// File: logic/axi_rsp_builder.sv
// ====================
// axi response builder
// one-cycle bresp per accepted write, single-beat rresp per avmm read strobe
// ====================
`timescale 1ns/1ps

module axi_rsp_builder #(
  parameter int DATA_W = bridge_pkg::DEF_DATA_W,
  parameter int ID_W   = bridge_pkg::DEF_ID_W
) (
  input  logic                  ip_clk,
  input  logic                  ip_rst_n,             // sync, active low
  // write acceptance from the mapper
  input  logic                  i_wr_acc,
  input  logic [ID_W-1:0]       i_wr_acc_id,
  // controller read return
  input  logic                  i_avmm_readdatavalid,
  input  logic [DATA_W-1:0]     i_avmm_readdata,
  input  logic                  i_avmm_read_poison,
  input  logic [ID_W-1:0]       i_head_id,            // oldest outstanding read id
  // write response
  output logic                  o_bvalid,
  output logic [ID_W-1:0]       o_bid,
  output bridge_pkg::axi_resp_e o_bresp,
  // read response
  output logic                  o_rvalid,
  output logic [ID_W-1:0]       o_rid,
  output logic [DATA_W-1:0]     o_rdata,
  output bridge_pkg::axi_resp_e o_rresp,
  output logic                  o_rlast,
  output logic                  o_ruser_poison,
  output logic                  o_rd_pop              // retire head id
);

  logic            bvalid_q; // write response pulse
  logic [ID_W-1:0] bid_q;    // staged write id

  // ====================
  // write response
  // ====================
  always_ff @(posedge ip_clk)
  begin
    if (!ip_rst_n)
      bvalid_q <= 1'b0;
    else
      bvalid_q <= i_wr_acc; // high for one cycle per write
  end

  always_ff @(posedge ip_clk)
  begin
    if (i_wr_acc)
      bid_q <= i_wr_acc_id;
  end

  assign o_bvalid = bvalid_q;
  assign o_bid    = bvalid_q ? bid_q : '0; // id only shown with the pulse
  assign o_bresp  = bridge_pkg::RESP_OKAY;

  // ====================
  // read response
  // ====================
  always_comb
  begin
    o_rid          = i_head_id;
    o_rdata        = i_avmm_readdata;
    o_rresp        = bridge_pkg::RESP_OKAY;
    o_rvalid       = 1'b0;
    o_rlast        = 1'b0;
    o_ruser_poison = 1'b0;
    o_rd_pop       = 1'b0;

    if (i_avmm_readdatavalid)
    begin
      o_rvalid       = 1'b1;
      o_rlast        = 1'b1;               // every read is one beat
      o_ruser_poison = i_avmm_read_poison;
      o_rd_pop       = 1'b1;               // controller returns in order
    end
  end

endmodule

// File: logic/rd_id_fifo.sv
// ====================
// read id buffer
// show-ahead circular fifo of outstanding read ids, almost full flag
// ====================
`timescale 1ns/1ps

module rd_id_fifo #(
  parameter int ID_W       = bridge_pkg::DEF_ID_W,
  parameter int FIFO_DEPTH = bridge_pkg::DEF_FIFO_DEPTH,
  parameter int AF_MARGIN  = bridge_pkg::DEF_AF_MARGIN
) (
  input  logic            ip_clk,
  input  logic            ip_rst_n,      // sync, active low
  input  logic            i_push,        // read accepted
  input  logic [ID_W-1:0] i_push_id,
  input  logic            i_pop,         // read data returned
  output logic [ID_W-1:0] o_head_id,     // oldest id, always visible
  output logic            o_almost_full
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] AF_LEVEL = CNT_W'(FIFO_DEPTH - AF_MARGIN);
  localparam logic [CNT_W-1:0] FULL_LVL = CNT_W'(FIFO_DEPTH);

  logic [ID_W-1:0]  mem [FIFO_DEPTH]; // id storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;            // entries in use
  logic             full;
  logic             empty;
  logic             do_push;
  logic             do_pop;

  // wrap at depth, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count == FULL_LVL);
  assign empty   = (count == '0);
  assign do_push = i_push & ~full;  // mapper throttles well before this
  assign do_pop  = i_pop & ~empty;

  // ====================
  // storage
  // ====================
  always_ff @(posedge ip_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= i_push_id;
  end

  assign o_head_id = mem[rd_ptr]; // show-ahead

  // ====================
  // pointers and count
  // ====================
  always_ff @(posedge ip_clk)
  begin
    if (!ip_rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);

      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

  // count is registered so the flag lags a push or pop by one cycle
  assign o_almost_full = (count >= AF_LEVEL);

endmodule

// File: logic/axi_req_mapper.sv
// ====================
// axi request mapper
// turns accepted aw/w or ar requests into avmm strobes, no staging
// ====================
`timescale 1ns/1ps

module axi_req_mapper #(
  parameter int ADDR_W = bridge_pkg::DEF_ADDR_W,
  parameter int DATA_W = bridge_pkg::DEF_DATA_W,
  parameter int ID_W   = bridge_pkg::DEF_ID_W
) (
  input  logic                                   i_avmm_ready,     // controller can take a request
  input  logic                                   i_rd_almost_full, // too many reads in flight
  // write address + data, taken together
  input  logic                                   i_awvalid,
  input  logic [ID_W-1:0]                        i_awid,
  input  logic [ADDR_W-1:0]                      i_awaddr,
  input  logic [DATA_W-1:0]                      i_wdata,
  input  logic [DATA_W/8-1:0]                    i_wstrb,
  input  logic                                   i_wuser,          // write poison
  // read address
  input  logic                                   i_arvalid,
  input  logic [ID_W-1:0]                        i_arid,
  input  logic [ADDR_W-1:0]                      i_araddr,
  // ready levels back to axi
  output logic                                   o_awready,
  output logic                                   o_wready,
  output logic                                   o_arready,
  // controller request side
  output logic                                   o_avmm_write,
  output logic                                   o_avmm_read,
  output logic [ADDR_W-bridge_pkg::LINE_OFS_W-1:0] o_avmm_address, // line address
  output logic [DATA_W-1:0]                      o_avmm_writedata,
  output logic [DATA_W/8-1:0]                    o_avmm_byteenable,
  output logic                                   o_avmm_write_poison,
  // internal hand-off
  output logic                                   o_wr_acc,         // to response builder
  output logic [ID_W-1:0]                        o_wr_acc_id,
  output logic                                   o_rd_push,        // to read id buffer
  output logic [ID_W-1:0]                        o_rd_push_id
);

  bridge_pkg::req_kind_e req_kind;

  // ====================
  // ready levels
  // ====================
  assign o_awready = i_avmm_ready;
  assign o_wready  = i_avmm_ready;
  assign o_arready = i_avmm_ready & ~i_rd_almost_full; // hold reads when id buffer fills

  // pick one request per cycle, write first
  always_comb
  begin
    if (i_awvalid && o_awready)
      req_kind = bridge_pkg::REQ_WRITE;
    else if (i_arvalid && o_arready)
      req_kind = bridge_pkg::REQ_READ; // a losing read just waits at the input
    else
      req_kind = bridge_pkg::REQ_NONE;
  end

  // ====================
  // controller strobes
  // ====================
  always_comb
  begin
    o_avmm_write        = 1'b0;
    o_avmm_read         = 1'b0;
    o_avmm_address      = '0;
    o_avmm_writedata    = '0;
    o_avmm_byteenable   = '0;
    o_avmm_write_poison = 1'b0;
    o_wr_acc            = 1'b0;
    o_wr_acc_id         = '0;
    o_rd_push           = 1'b0;
    o_rd_push_id        = '0;

    case (req_kind)
      bridge_pkg::REQ_WRITE:
      begin
        o_avmm_write        = 1'b1;
        o_avmm_address      = i_awaddr[ADDR_W-1:bridge_pkg::LINE_OFS_W]; // drop byte offset
        o_avmm_writedata    = i_wdata;
        o_avmm_byteenable   = i_wstrb;
        o_avmm_write_poison = i_wuser;
        o_wr_acc            = 1'b1; // bresp goes out next cycle
        o_wr_acc_id         = i_awid;
      end
      bridge_pkg::REQ_READ:
      begin
        o_avmm_read    = 1'b1;
        o_avmm_address = i_araddr[ADDR_W-1:bridge_pkg::LINE_OFS_W];
        o_rd_push      = 1'b1;  // remember id, data returns in order
        o_rd_push_id   = i_arid;
      end
      default:
      begin
        o_avmm_write = 1'b0; // nothing this cycle
      end
    endcase
  end

endmodule

// File: logic/bridge_pkg.sv
// ====================
// axi to avmm bridge shared definitions
// request kinds, response codes and default widths
// ====================

package bridge_pkg;

  // ====================
  // default sizes
  // ====================
  localparam int DEF_ADDR_W     = 52;  // axi byte address
  localparam int LINE_OFS_W     = 6;   // 64 byte cache line offset
  localparam int DEF_DATA_W     = 512; // one full line per beat
  localparam int DEF_ID_W       = 8;
  localparam int DEF_FIFO_DEPTH = 16;  // outstanding read ids

  // almost full is raised at depth minus this margin
  localparam int DEF_AF_MARGIN  = 8;

  // ====================
  // enums
  // ====================

  // request picked for the controller in a cycle
  typedef enum logic [1:0] {
    REQ_NONE  = 2'd0, // idle or not ready
    REQ_WRITE = 2'd1, // write wins a tie
    REQ_READ  = 2'd2
  } req_kind_e;

  // axi bresp / rresp encoding
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00, // the only code the bridge drives
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

endpackage
